// File: zx_avr_link_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// avr spi link shared types
// register numbers and frame states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ZX_AVR_LINK_PKG_SV
`define ZX_AVR_LINK_PKG_SV

package zx_avr_link_pkg;

	// one spi byte, register contents, readback
	typedef logic [7:0] byte_t;
	// register number, shifted lsb first while cs high
	typedef logic [7:0] reg_num_t;
	// keyboard row select
	typedef logic [2:0] row_idx_t;
	// rom page for z80 reset
	typedef logic [1:0] rom_page_t;

	// frame phase, address while cs high
	typedef enum logic
	{
		LINK_ADDR = 1'b0,
		LINK_DATA = 1'b1
	} link_state_t;

	// register map
	localparam reg_num_t REG_KBD     = 8'h10;
	localparam reg_num_t REG_KBD_RST = 8'h11;
	localparam reg_num_t REG_MUS_X   = 8'h20;
	localparam reg_num_t REG_MUS_Y   = 8'h21;
	localparam reg_num_t REG_MUS_BTN = 8'h22;
	localparam reg_num_t REG_JOY     = 8'h23;
	localparam reg_num_t REG_RESET   = 8'h30;
	localparam reg_num_t REG_WAIT    = 8'h40;
	localparam reg_num_t REG_GLUCK   = 8'h41;
	localparam reg_num_t REG_COMPORT = 8'h42;
	localparam reg_num_t REG_CFG0    = 8'h50;

endpackage

`endif

// File: spi_sync.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi pin synchroniser
// edge pulses for cs and sck
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module spi_sync #(
	parameter int SYNC_STAGES = 2
) (
	input  logic fclk,
	input  logic arst_n,
	input  logic spics_n,
	input  logic spido,
	input  logic spick,
	output logic cs_n_s,
	output logic sdo_s,
	output logic cs_fall,
	output logic cs_rise,
	output logic sck_rise
);

	// cs and sck carry one extra stage for edge detect
	logic [SYNC_STAGES:0]   cs_chain;
	logic [SYNC_STAGES-1:0] sdo_chain;
	logic [SYNC_STAGES:0]   sck_chain;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			// idle bus, cs high and clock low
			cs_chain  <= '1;
			sdo_chain <= '0;
			sck_chain <= '0;
		end
		else
		begin
			cs_chain  <= {cs_chain[SYNC_STAGES-1:0], spics_n};
			sdo_chain <= {sdo_chain[SYNC_STAGES-2:0], spido};
			sck_chain <= {sck_chain[SYNC_STAGES-1:0], spick};
		end
	end

	// last sync stage is the usable level
	assign cs_n_s = cs_chain[SYNC_STAGES-1];
	assign sdo_s  = sdo_chain[SYNC_STAGES-1];

	// compare against the extra stage
	assign cs_fall  = cs_chain[SYNC_STAGES] & ~cs_chain[SYNC_STAGES-1];
	assign cs_rise  = ~cs_chain[SYNC_STAGES] & cs_chain[SYNC_STAGES-1];
	assign sck_rise = ~sck_chain[SYNC_STAGES] & sck_chain[SYNC_STAGES-1];

endmodule

// File: spi_frame_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi frame phase tracker
// steers sck edges to addr or data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module spi_frame_fsm
	import zx_avr_link_pkg::*;
(
	input  logic fclk,
	input  logic arst_n,
	input  logic cs_fall,
	input  logic cs_rise,
	input  logic sck_rise,
	output logic addr_shift,
	output logic data_shift,
	output logic frame_open,
	output logic frame_close
);

	link_state_t state;
	link_state_t state_nx;

	always_comb
	begin
		state_nx = state;
		case (state)
			// data phase begins when cs goes low
			LINK_ADDR: if (cs_fall) state_nx = LINK_DATA;
			// cs back high commits the access
			LINK_DATA: if (cs_rise) state_nx = LINK_ADDR;
			default:   state_nx = LINK_ADDR;
		endcase
	end

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			state <= LINK_ADDR;
		else
			state <= state_nx;
	end

	// every sck edge goes to exactly one shifter
	assign addr_shift  = sck_rise && (state == LINK_ADDR);
	assign data_shift  = sck_rise && (state == LINK_DATA);

	// phase change pulses in the cycle of the transition
	assign frame_open  = (state == LINK_ADDR) && (state_nx == LINK_DATA);
	assign frame_close = (state == LINK_DATA) && (state_nx == LINK_ADDR);

	// synchroniser must never report both cs edges at once
	a_cs_edges_excl: assert property (@(posedge fclk) disable iff (!arst_n)
		!(cs_fall && cs_rise));

	// cs only falls while the address phase is open
	a_open_from_addr: assert property (@(posedge fclk) disable iff (!arst_n)
		cs_fall |-> (state == LINK_ADDR));

endmodule

// File: bit_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// keyboard bit and row counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module bit_counter
	import zx_avr_link_pkg::*;
#(
	parameter int BYTE_BITS = 8
) (
	input  logic     fclk,
	input  logic     arst_n,
	input  logic     data_shift,
	input  logic     kbd_restart,
	output logic     bit_done_byte,
	output row_idx_t row_idx
);

	localparam int BIT_W = $clog2(BYTE_BITS);

	logic [BIT_W-1:0] bit_cnt;
	logic             last_bit;

	// bit about to shift is the last one of the byte
	assign last_bit      = (bit_cnt == BIT_W'(BYTE_BITS - 1));
	assign bit_done_byte = data_shift && last_bit;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			bit_cnt <= '0;
			row_idx <= '0;
		end
		else if (kbd_restart)
		begin
			// stream restart, back to row 0 bit 0
			bit_cnt <= '0;
			row_idx <= '0;
		end
		else if (data_shift)
		begin
			if (last_bit)
			begin
				bit_cnt <= '0;
				// row wraps after the last row
				row_idx <= row_idx + 1'b1;
			end
			else
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// restart comes at cs rise, never during a shift
	a_restart_no_shift: assert property (@(posedge fclk) disable iff (!arst_n)
		!(kbd_restart && data_shift));

endmodule

// File: spi_shifter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi shift registers
// regnum in, data in, readback out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module spi_shifter
	import zx_avr_link_pkg::*;
(
	input  logic     fclk,
	input  logic     arst_n,
	input  logic     addr_shift,
	input  logic     data_shift,
	input  logic     frame_open,
	input  logic     frame_close,
	input  logic     sdo_s,
	input  byte_t    status_in,
	input  byte_t    rd_byte,
	output reg_num_t reg_num,
	output byte_t    data_word,
	output logic     spidi
);

	byte_t data_sr;
	byte_t out_sr;

	// register number, lsb first while cs high
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			reg_num <= '0;
		else if (frame_close)
			// fresh number needed before each frame
			reg_num <= '0;
		else if (addr_shift)
			reg_num <= {sdo_s, reg_num[7:1]};
	end

	// incoming data, current sdo bit already on top
	assign data_word = {sdo_s, data_sr[7:1]};

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			data_sr <= '0;
		else if (data_shift)
			data_sr <= data_word;
	end

	// outgoing byte
	// status while cs high, readback while cs low
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			out_sr <= '0;
		else if (frame_close)
			out_sr <= status_in;
		else if (frame_open)
			out_sr <= rd_byte;
		else if (addr_shift || data_shift)
			// zeros follow the byte
			out_sr <= {1'b0, out_sr[7:1]};
	end

	assign spidi = out_sr[0];

endmodule

// File: zx_reg_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// zx register bank
// decode, shadows, strobes, readback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module zx_reg_bank
	import zx_avr_link_pkg::*;
(
	input  logic      fclk,
	input  logic      arst_n,
	input  reg_num_t  reg_num,
	input  logic      sdo_s,
	input  logic      data_shift,
	input  logic      frame_close,
	input  logic      bit_done_byte,
	input  byte_t     data_word,
	input  byte_t     wait_write,
	input  byte_t     gluclock_addr,
	input  byte_t     comport_addr,
	output byte_t     rd_byte,
	output logic      kbd_restart,
	output byte_t     kbd_out,
	output logic      kbd_stb,
	output byte_t     mus_out,
	output logic      mus_xstb,
	output logic      mus_ystb,
	output logic      mus_btnstb,
	output logic      kj_stb,
	output byte_t     config0,
	output logic      cfg_stb,
	output logic      tape_in_bit,
	output byte_t     wait_read,
	output logic      wait_end,
	output logic      genrst,
	output rom_page_t rstrom
);

	logic [3:0] grp;
	logic [1:0] sub;
	logic       sel_kbd, sel_kbd_rst, sel_mus_x, sel_mus_y, sel_mus_btn, sel_joy;
	logic       sel_rst, sel_wait, sel_gluck, sel_comport, sel_cfg0, sel_mus;
	logic       any_commit;

	// per-register shift copies
	byte_t mouse_sh;
	byte_t rst_sh;
	byte_t wait_sh;
	byte_t cfg_sh;

	// high nibble picks the group and low bits the register
	assign grp = reg_num[7:4];
	assign sub = reg_num[1:0];

	assign sel_kbd     = (grp == REG_KBD[7:4]) && (reg_num[0] == REG_KBD[0]);
	assign sel_kbd_rst = (grp == REG_KBD_RST[7:4]) && (reg_num[0] == REG_KBD_RST[0]);
	assign sel_mus_x   = (grp == REG_MUS_X[7:4]) && (sub == REG_MUS_X[1:0]);
	assign sel_mus_y   = (grp == REG_MUS_Y[7:4]) && (sub == REG_MUS_Y[1:0]);
	assign sel_mus_btn = (grp == REG_MUS_BTN[7:4]) && (sub == REG_MUS_BTN[1:0]);
	assign sel_joy     = (grp == REG_JOY[7:4]) && (sub == REG_JOY[1:0]);
	assign sel_rst     = (grp == REG_RESET[7:4]);
	assign sel_wait    = (grp == REG_WAIT[7:4]) && (sub == REG_WAIT[1:0]);
	assign sel_gluck   = (grp == REG_GLUCK[7:4]) && (sub == REG_GLUCK[1:0]);
	assign sel_comport = (grp == REG_COMPORT[7:4]) && (sub == REG_COMPORT[1:0]);
	assign sel_cfg0    = (grp == REG_CFG0[7:4]);
	// x, y, buttons and joystick share one buffer
	assign sel_mus     = sel_mus_x || sel_mus_y || sel_mus_btn || sel_joy;

	// keyboard is streamed without a shadow
	assign kbd_out     = sel_kbd ? data_word : '0;
	assign kbd_stb     = bit_done_byte && sel_kbd;
	assign kbd_restart = frame_close && sel_kbd_rst;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			mouse_sh <= '0;
			rst_sh   <= '0;
			wait_sh  <= '0;
			cfg_sh   <= '0;
		end
		else if (data_shift)
		begin
			if (sel_mus)
				mouse_sh <= {sdo_s, mouse_sh[7:1]};
			if (sel_rst)
				rst_sh <= {sdo_s, rst_sh[7:1]};
			if (sel_wait)
				wait_sh <= {sdo_s, wait_sh[7:1]};
			if (sel_cfg0)
				cfg_sh <= {sdo_s, cfg_sh[7:1]};
		end
	end

	// commit at cs rise with strobes one fclk later
	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			mus_xstb   <= 1'b0;
			mus_ystb   <= 1'b0;
			mus_btnstb <= 1'b0;
			kj_stb     <= 1'b0;
			cfg_stb    <= 1'b0;
			genrst     <= 1'b0;
			wait_end   <= 1'b0;
			config0    <= '0;
			rstrom     <= '0;
			wait_read  <= '0;
		end
		else
		begin
			mus_xstb   <= frame_close && sel_mus_x;
			mus_ystb   <= frame_close && sel_mus_y;
			mus_btnstb <= frame_close && sel_mus_btn;
			kj_stb     <= frame_close && sel_joy;
			cfg_stb    <= frame_close && sel_cfg0;
			genrst     <= frame_close && sel_rst;
			wait_end   <= frame_close && sel_wait;
			// latches land together with their strobe
			if (frame_close && sel_cfg0)
				config0 <= cfg_sh;
			if (frame_close && sel_rst)
				rstrom <= rst_sh[5:4];
			if (frame_close && sel_wait)
				wait_read <= wait_sh;
		end
	end

	assign mus_out     = mouse_sh;
	assign tape_in_bit = config0[2];

	// unmapped registers read back as all ones
	always_comb
	begin
		if (sel_wait)
			rd_byte = wait_write;
		else if (sel_gluck)
			rd_byte = gluclock_addr;
		else if (sel_comport)
			rd_byte = comport_addr;
		else
			rd_byte = 8'hFF;
	end

	assign any_commit = mus_xstb || mus_ystb || mus_btnstb || kj_stb ||
		cfg_stb || genrst || wait_end;

	// one commit per frame, never two cycles running
	a_one_commit: assert property (@(posedge fclk) disable iff (!arst_n)
		any_commit |=> !any_commit);

endmodule

// File: zx_avr_link.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// avr to zx spi register link
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module zx_avr_link
	import zx_avr_link_pkg::*;
#(
	parameter int SYNC_STAGES = 2,
	parameter int BYTE_BITS   = 8
) (
	input  logic      fclk,
	input  logic      arst_n,
	// avr spi pins
	input  logic      spics_n,
	input  logic      spido,
	input  logic      spick,
	output logic      spidi,
	// readback sources
	input  byte_t     status_in,
	input  byte_t     wait_write,
	input  byte_t     gluclock_addr,
	input  byte_t     comport_addr,
	// sideband
	output byte_t     kbd_out,
	output row_idx_t  kbd_out_sel,
	output logic      kbd_stb,
	output byte_t     mus_out,
	output logic      mus_xstb,
	output logic      mus_ystb,
	output logic      mus_btnstb,
	output logic      kj_stb,
	output byte_t     config0,
	output logic      cfg_stb,
	output logic      tape_in_bit,
	output byte_t     wait_read,
	output logic      wait_end,
	output logic      genrst,
	output rom_page_t rstrom
);

	logic     cs_n_s, sdo_s, cs_fall, cs_rise, sck_rise;
	logic     addr_shift, data_shift, frame_open, frame_close;
	logic     bit_done_byte, kbd_restart;
	reg_num_t reg_num;
	byte_t    data_word;
	byte_t    rd_byte;

	spi_sync #(
		.SYNC_STAGES(SYNC_STAGES)
	) spi_sync_inst (
		.fclk    (fclk),
		.arst_n  (arst_n),
		.spics_n (spics_n),
		.spido   (spido),
		.spick   (spick),
		.cs_n_s  (cs_n_s),
		.sdo_s   (sdo_s),
		.cs_fall (cs_fall),
		.cs_rise (cs_rise),
		.sck_rise(sck_rise)
	);

	spi_frame_fsm spi_frame_fsm_inst (
		.fclk       (fclk),
		.arst_n     (arst_n),
		.cs_fall    (cs_fall),
		.cs_rise    (cs_rise),
		.sck_rise   (sck_rise),
		.addr_shift (addr_shift),
		.data_shift (data_shift),
		.frame_open (frame_open),
		.frame_close(frame_close)
	);

	bit_counter #(
		.BYTE_BITS(BYTE_BITS)
	) bit_counter_inst (
		.fclk         (fclk),
		.arst_n       (arst_n),
		.data_shift   (data_shift),
		.kbd_restart  (kbd_restart),
		.bit_done_byte(bit_done_byte),
		.row_idx      (kbd_out_sel)
	);

	spi_shifter spi_shifter_inst (
		.fclk       (fclk),
		.arst_n     (arst_n),
		.addr_shift (addr_shift),
		.data_shift (data_shift),
		.frame_open (frame_open),
		.frame_close(frame_close),
		.sdo_s      (sdo_s),
		.status_in  (status_in),
		.rd_byte    (rd_byte),
		.reg_num    (reg_num),
		.data_word  (data_word),
		.spidi      (spidi)
	);

	zx_reg_bank zx_reg_bank_inst (
		.fclk         (fclk),
		.arst_n       (arst_n),
		.reg_num      (reg_num),
		.sdo_s        (sdo_s),
		.data_shift   (data_shift),
		.frame_close  (frame_close),
		.bit_done_byte(bit_done_byte),
		.data_word    (data_word),
		.wait_write   (wait_write),
		.gluclock_addr(gluclock_addr),
		.comport_addr (comport_addr),
		.rd_byte      (rd_byte),
		.kbd_restart  (kbd_restart),
		.kbd_out      (kbd_out),
		.kbd_stb      (kbd_stb),
		.mus_out      (mus_out),
		.mus_xstb     (mus_xstb),
		.mus_ystb     (mus_ystb),
		.mus_btnstb   (mus_btnstb),
		.kj_stb       (kj_stb),
		.config0      (config0),
		.cfg_stb      (cfg_stb),
		.tape_in_bit  (tape_in_bit),
		.wait_read    (wait_read),
		.wait_end     (wait_end),
		.genrst       (genrst),
		.rstrom       (rstrom)
	);

	// data bits only ever arrive while the pin level says cs is low
	a_data_in_frame: assert property (@(posedge fclk) disable iff (!arst_n)
		data_shift |-> !cs_n_s);

endmodule

// File: link_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// link checker for the spi link
// strobe counts and values per frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module link_checker
	import zx_avr_link_pkg::*;
#(
	parameter int MAX_BYTES = 5
) (
	input  logic                  fclk,
	input  logic                  arst_n,
	// expectations for the current table row
	input  logic [8*16-1:0]       test_name,
	input  byte_t [MAX_BYTES-1:0] exp_data,
	input  int                    exp_nbytes,
	input  logic [7:0]            exp_stb,
	input  byte_t                 exp_rd,
	input  byte_t                 exp_status,
	input  logic                  status_valid,
	// bytes the spi master collected
	input  byte_t                 got_status,
	input  byte_t                 got_rd,
	input  logic                  row_end,
	// watched dut outputs
	input  logic                  spidi,
	input  byte_t                 kbd_out,
	input  row_idx_t              kbd_out_sel,
	input  logic                  kbd_stb,
	input  byte_t                 mus_out,
	input  logic                  mus_xstb,
	input  logic                  mus_ystb,
	input  logic                  mus_btnstb,
	input  logic                  kj_stb,
	input  byte_t                 config0,
	input  logic                  cfg_stb,
	input  logic                  tape_in_bit,
	input  byte_t                 wait_read,
	input  logic                  wait_end,
	input  logic                  genrst,
	input  rom_page_t             rstrom,
	output int                    value_errs,
	output int                    strobe_errs
);

	logic [7:0] stb_vec;
	int         stb_cnt [8];
	logic       reset_seen;
	logic       cfg_valid;
	logic       wait_valid;
	byte_t      cfg_hold;
	byte_t      wait_hold;
	string      stb_names [8] = '{"kbd_stb", "mus_xstb", "mus_ystb", "mus_btnstb",
		"kj_stb", "cfg_stb", "genrst", "wait_end"};

	// same bit order as the strobe masks of the table
	assign stb_vec = {wait_end, genrst, cfg_stb, kj_stb, mus_btnstb, mus_ystb, mus_xstb, kbd_stb};

	task automatic compare_byte(input string what, input byte_t exp, input byte_t act);
		if (exp !== act)
		begin
			$display("FAILED %0s: %0s expected 0x%02h actual 0x%02h",
				test_name, what, exp, act);
			value_errs++;
		end
	endtask

	task automatic expect_count(input string what, input int exp, input int act);
		if (exp != act)
		begin
			$display("FAILED %0s: %0s count expected %0d actual %0d",
				test_name, what, exp, act);
			strobe_errs++;
		end
	endtask

	// idle outputs right after reset release
	task automatic verify_reset_state();
		compare_byte("strobes at reset", 8'h00, stb_vec);
		compare_byte("config0 at reset", 8'h00, config0);
		compare_byte("rstrom at reset", 8'h00, {6'd0, rstrom});
		compare_byte("wait_read at reset", 8'h00, wait_read);
		compare_byte("spidi at reset", 8'h00, {7'd0, spidi});
	endtask

	task automatic tally_strobes();
		int n;
		n = stb_cnt[0];
		// keyboard pulse n carries byte n on row n
		if (kbd_stb)
		begin
			if (n < MAX_BYTES)
				compare_byte("kbd_out", exp_data[n], kbd_out);
			compare_byte("kbd_out_sel", 8'(n), {5'd0, kbd_out_sel});
		end
		if (mus_xstb || mus_ystb || mus_btnstb || kj_stb)
			compare_byte("mus_out", exp_data[0], mus_out);
		// tape in is bit 2 of the config byte
		if (cfg_stb)
		begin
			compare_byte("config0", exp_data[0], config0);
			compare_byte("tape_in_bit", {7'd0, exp_data[0][2]}, {7'd0, tape_in_bit});
			cfg_hold  = exp_data[0];
			cfg_valid = 1'b1;
		end
		// rom page from bits 5:4
		if (genrst)
			compare_byte("rstrom", {6'd0, exp_data[0][5:4]}, {6'd0, rstrom});
		if (wait_end)
		begin
			compare_byte("wait_read", exp_data[0], wait_read);
			wait_hold  = exp_data[0];
			wait_valid = 1'b1;
		end
		for (int k = 0; k < 8; k++)
		begin
			if (stb_vec[k])
				stb_cnt[k]++;
		end
	endtask

	task automatic close_row();
		int want;
		for (int k = 0; k < 8; k++)
		begin
			want = 0;
			// keyboard pulses once per byte, the rest once per frame
			if (exp_stb[k])
				want = (k == 0) ? exp_nbytes : 1;
			expect_count(stb_names[k], want, stb_cnt[k]);
			stb_cnt[k] = 0;
		end
		if (status_valid)
			compare_byte("status", exp_status, got_status);
		if (exp_nbytes > 0)
			compare_byte("readback", exp_rd, got_rd);
		// latched values hold until the next write
		if (cfg_valid)
			compare_byte("config0 held", cfg_hold, config0);
		if (wait_valid)
			compare_byte("wait_read held", wait_hold, wait_read);
	endtask

	// mid-cycle sampling, outputs settled
	always @(negedge fclk)
	begin
		if (!arst_n)
		begin
			value_errs  = 0;
			strobe_errs = 0;
			reset_seen  = 1'b0;
			cfg_valid   = 1'b0;
			wait_valid  = 1'b0;
			for (int k = 0; k < 8; k++)
				stb_cnt[k] = 0;
		end
		else
		begin
			if (!reset_seen)
			begin
				verify_reset_state();
				reset_seen = 1'b1;
			end
			tally_strobes();
			if (row_end)
				close_row();
		end
	end

endmodule

// File: tb_zx_avr_link.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the avr spi link
// bit-bang master, table of frames
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_zx_avr_link
	import zx_avr_link_pkg::*;
();

	localparam int CLK_PERIOD = 4;
	localparam int RST_CYCLES = 4;
	// fclk cycles per sck half period
	localparam int HALF       = 8;
	localparam int NROWS      = 12;
	localparam int MAX_BYTES  = 5;
	// table length times 40 sck periods
	localparam int WATCHDOG   = (NROWS * 40 * 2 * HALF + RST_CYCLES) * CLK_PERIOD;

	// strobe masks, bit order as in the checker
	localparam logic [7:0] STB_NONE    = 8'h00;
	localparam logic [7:0] STB_KBD     = 8'h01;
	localparam logic [7:0] STB_MUS_X   = 8'h02;
	localparam logic [7:0] STB_MUS_Y   = 8'h04;
	localparam logic [7:0] STB_MUS_BTN = 8'h08;
	localparam logic [7:0] STB_JOY     = 8'h10;
	localparam logic [7:0] STB_CFG     = 8'h20;
	localparam logic [7:0] STB_GENRST  = 8'h40;
	localparam logic [7:0] STB_WAIT    = 8'h80;
	localparam reg_num_t   REG_UNMAPPED = 8'h60;

	logic      fclk = 1'b0;
	logic      arst_n;
	logic      spics_n, spido, spick, spidi;
	byte_t     status_in, wait_write, gluclock_addr, comport_addr;
	byte_t     kbd_out, mus_out, config0, wait_read;
	row_idx_t  kbd_out_sel;
	logic      kbd_stb, mus_xstb, mus_ystb, mus_btnstb, kj_stb;
	logic      cfg_stb, tape_in_bit, wait_end, genrst;
	rom_page_t rstrom;

	// stimulus table
	logic [8*16-1:0]       name_tab   [NROWS];
	reg_num_t              reg_tab    [NROWS];
	int                    nbytes_tab [NROWS];
	byte_t [MAX_BYTES-1:0] data_tab   [NROWS];
	byte_t                 rd_tab     [NROWS];
	logic [7:0]            stb_tab    [NROWS];

	// current row, as seen by the checker
	logic [8*16-1:0]       cur_name;
	byte_t [MAX_BYTES-1:0] cur_data;
	int                    cur_nbytes;
	logic [7:0]            cur_stb;
	byte_t                 cur_rd, cur_status, got_status, got_rd;
	logic                  status_valid, row_end;
	int                    value_errs, strobe_errs;

	always #(CLK_PERIOD / 2) fclk = ~fclk;

	zx_avr_link #(
		.SYNC_STAGES(2),
		.BYTE_BITS  (8)
	) zx_avr_link_inst (
		.fclk(fclk), .arst_n(arst_n),
		.spics_n(spics_n), .spido(spido), .spick(spick), .spidi(spidi),
		.status_in(status_in), .wait_write(wait_write),
		.gluclock_addr(gluclock_addr), .comport_addr(comport_addr),
		.kbd_out(kbd_out), .kbd_out_sel(kbd_out_sel), .kbd_stb(kbd_stb),
		.mus_out(mus_out), .mus_xstb(mus_xstb), .mus_ystb(mus_ystb),
		.mus_btnstb(mus_btnstb), .kj_stb(kj_stb),
		.config0(config0), .cfg_stb(cfg_stb), .tape_in_bit(tape_in_bit),
		.wait_read(wait_read), .wait_end(wait_end),
		.genrst(genrst), .rstrom(rstrom)
	);

	link_checker #(
		.MAX_BYTES(MAX_BYTES)
	) link_checker_inst (
		.fclk(fclk), .arst_n(arst_n),
		.test_name(cur_name), .exp_data(cur_data), .exp_nbytes(cur_nbytes),
		.exp_stb(cur_stb), .exp_rd(cur_rd), .exp_status(cur_status),
		.status_valid(status_valid), .got_status(got_status), .got_rd(got_rd),
		.row_end(row_end), .spidi(spidi),
		.kbd_out(kbd_out), .kbd_out_sel(kbd_out_sel), .kbd_stb(kbd_stb),
		.mus_out(mus_out), .mus_xstb(mus_xstb), .mus_ystb(mus_ystb),
		.mus_btnstb(mus_btnstb), .kj_stb(kj_stb),
		.config0(config0), .cfg_stb(cfg_stb), .tape_in_bit(tape_in_bit),
		.wait_read(wait_read), .wait_end(wait_end),
		.genrst(genrst), .rstrom(rstrom),
		.value_errs(value_errs), .strobe_errs(strobe_errs)
	);

	// readback map, unmapped reads as 0xFF
	function automatic byte_t readback_for(input reg_num_t regn);
		case (regn)
			REG_WAIT:    return wait_write;
			REG_GLUCK:   return gluclock_addr;
			REG_COMPORT: return comport_addr;
			default:     return 8'hFF;
		endcase
	endfunction

	task automatic add_row(input int idx, input logic [8*16-1:0] name, input reg_num_t regn,
		input int nbytes, input logic [7:0] stb);
		name_tab[idx]   = name;
		reg_tab[idx]    = regn;
		nbytes_tab[idx] = nbytes;
		stb_tab[idx]    = stb;
		rd_tab[idx]     = readback_for(regn);
		for (int b = 0; b < MAX_BYTES; b++)
			data_tab[idx][b] = 8'($urandom());
	endtask

	task automatic build_table();
		add_row(0, "cfg0_write", REG_CFG0, 1, STB_CFG);
		add_row(1, "rom_reset", REG_RESET, 1, STB_GENRST);
		add_row(2, "mouse_x", REG_MUS_X, 1, STB_MUS_X);
		add_row(3, "mouse_y", REG_MUS_Y, 1, STB_MUS_Y);
		add_row(4, "mouse_btn", REG_MUS_BTN, 1, STB_MUS_BTN);
		add_row(5, "joystick", REG_JOY, 1, STB_JOY);
		// restart first, so the stream starts on row 0
		add_row(6, "kbd_restart", REG_KBD_RST, 0, STB_NONE);
		add_row(7, "kbd_stream", REG_KBD, 5, STB_KBD);
		add_row(8, "wait_port", REG_WAIT, 1, STB_WAIT);
		add_row(9, "gluclock_read", REG_GLUCK, 1, STB_NONE);
		add_row(10, "comport_read", REG_COMPORT, 1, STB_NONE);
		add_row(11, "unmapped_read", REG_UNMAPPED, 1, STB_NONE);
	endtask

	// inputs change 1 unit after the rising fclk
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge fclk);
		#1;
	endtask

	// sdo set with sck low, spidi taken as sck rises
	task automatic shift_bit(input logic b, output logic r);
		spick = 1'b0;
		spido = b;
		wait_cycles(HALF);
		spick = 1'b1;
		r = spidi;
		wait_cycles(HALF);
	endtask

	task automatic run_frame(input int row);
		logic  r;
		byte_t rx;
		// register number lsb first, status comes back
		rx = '0;
		for (int b = 0; b < 8; b++)
		begin
			shift_bit(reg_tab[row][b], r);
			rx = {r, rx[7:1]};
		end
		got_status = rx;
		spick = 1'b0;
		wait_cycles(HALF);
		spics_n = 1'b0;
		wait_cycles(HALF);
		// data phase, readback is the first byte out
		rx = '0;
		for (int n = 0; n < nbytes_tab[row]; n++)
		begin
			for (int b = 0; b < 8; b++)
			begin
				shift_bit(data_tab[row][n][b], r);
				if (n == 0)
					rx = {r, rx[7:1]};
			end
		end
		got_rd = rx;
		spick = 1'b0;
		wait_cycles(HALF);
		// cs rise commits the access
		spics_n = 1'b1;
		wait_cycles(HALF);
	endtask

	initial
	begin
		void'($urandom(32'hd77cb2cf));
		arst_n        = 1'b0;
		spics_n       = 1'b1;
		spido         = 1'b0;
		spick         = 1'b0;
		status_in     = 8'($urandom());
		wait_write    = 8'($urandom());
		gluclock_addr = 8'($urandom());
		comport_addr  = 8'($urandom());
		cur_name      = "reset_state";
		cur_data      = '0;
		cur_nbytes    = 0;
		cur_stb       = STB_NONE;
		cur_rd        = '0;
		cur_status    = '0;
		got_status    = '0;
		got_rd        = '0;
		status_valid  = 1'b0;
		row_end       = 1'b0;
		build_table();
		repeat (RST_CYCLES) @(posedge fclk);
		#1;
		arst_n = 1'b1;
		wait_cycles(2 * HALF);
		for (int i = 0; i < NROWS; i++)
		begin
			cur_name   = name_tab[i];
			cur_data   = data_tab[i];
			cur_nbytes = nbytes_tab[i];
			cur_stb    = stb_tab[i];
			cur_rd     = rd_tab[i];
			// status was loaded at the previous frame close
			cur_status   = status_in;
			status_valid = (i > 0);
			status_in    = 8'($urandom());
			run_frame(i);
			row_end = 1'b1;
			wait_cycles(1);
			row_end = 1'b0;
		end
		$display("errors: %0d value, %0d strobe count", value_errs, strobe_errs);
		if (value_errs == 0 && strobe_errs == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// watchdog
	initial
	begin
		#(WATCHDOG);
		$display("timeout: the frames did not finish within %0d time units", WATCHDOG);
		$display("Verification failed");
		$finish;
	end

endmodule

// File: zx_avr_link.f
zx_avr_link_pkg.sv
spi_sync.sv
spi_frame_fsm.sv
bit_counter.sv
spi_shifter.sv
zx_reg_bank.sv
zx_avr_link.sv
link_checker.sv
tb_zx_avr_link.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_zx_avr_link
FILELIST  ?= zx_avr_link.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Verification passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
